//--- design/l1_coherence_pkg.sv
/* Shared widths, status bit positions and snoop codes for the L1 coherence directory.
   Used by the RTL and the testbench through scoped names. */
`default_nettype none

package l1_coherence_pkg;

  // address split: | tag | set index | byte offset |
  localparam int ADDR_W    = 32;
  localparam int OFFSET_W  = 4;
  localparam int SET_IDX_W = 4;
  localparam int TAG_W     = ADDR_W - OFFSET_W - SET_IDX_W;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [SET_IDX_W-1:0] set_idx_t;

  // per line status bits
  typedef logic [2:0] line_status_t;

  localparam int ST_VALID  = 0;
  localparam int ST_DIRTY  = 1;
  localparam int ST_SHARED = 2;

  // ACE snoop codes handled by the directory
  typedef logic [3:0] snoop_op_t;

  localparam snoop_op_t SNOOP_READ_ONCE     = 4'd0;
  localparam snoop_op_t SNOOP_READ_SHARED   = 4'd1;
  localparam snoop_op_t SNOOP_READ_UNIQUE   = 4'd7;
  localparam snoop_op_t SNOOP_CLEAN_INVALID = 4'd9;

  // replacement LFSR
  typedef logic [7:0] lfsr_t;

endpackage

`default_nettype wire

//--- design/tag_status_array.sv
/* Tag and status storage for every set and way, built from flops.
   One registered read port with write-first forwarding and one write port. */
`default_nettype none

module tag_status_array #(
  parameter int NUM_WAYS = 4
) (
  input  wire                                        clk_i,
  input  wire                                        rst_i,
  input  wire                                        rd_en_i,
  input  wire  l1_coherence_pkg::set_idx_t           rd_set_i,
  input  wire                                        wr_en_i,
  input  wire  l1_coherence_pkg::set_idx_t           wr_set_i,
  input  wire  [$clog2(NUM_WAYS)-1:0]                wr_way_i,
  input  wire  l1_coherence_pkg::tag_t               wr_tag_i,
  input  wire  l1_coherence_pkg::line_status_t       wr_status_i,
  output l1_coherence_pkg::tag_t       [NUM_WAYS-1:0] rd_tags_o,
  output l1_coherence_pkg::line_status_t [NUM_WAYS-1:0] rd_status_o
);

  localparam int NUM_SETS = 2 ** l1_coherence_pkg::SET_IDX_W;

  l1_coherence_pkg::tag_t         [NUM_WAYS-1:0] tags_q   [NUM_SETS];
  l1_coherence_pkg::line_status_t [NUM_WAYS-1:0] status_q [NUM_SETS];

  l1_coherence_pkg::tag_t         [NUM_WAYS-1:0] rd_tags_d;
  l1_coherence_pkg::line_status_t [NUM_WAYS-1:0] rd_status_d;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tags_q[wr_set_i][wr_way_i] <= wr_tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        status_q[s] <= '0;
      end
    end else if (wr_en_i) begin
      status_q[wr_set_i][wr_way_i] <= wr_status_i;
    end
  end

  always_comb begin
    rd_tags_d   = tags_q[rd_set_i];
    rd_status_d = status_q[rd_set_i];
    // a write to the same set in this cycle wins over the stored line
    if (wr_en_i && (wr_set_i == rd_set_i)) begin
      rd_tags_d[wr_way_i]   = wr_tag_i;
      rd_status_d[wr_way_i] = wr_status_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_tags_o <= rd_tags_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_status_o <= '0;
    end else if (rd_en_i) begin
      rd_status_o <= rd_status_d;
    end
  end

endmodule

`default_nettype wire

//--- design/way_lookup.sv
/* Tag compare across the ways of one set.
   Reports the hit way with its status and the lowest way that is still free. */
`default_nettype none

module way_lookup #(
  parameter int NUM_WAYS = 4
) (
  input  wire  l1_coherence_pkg::tag_t                        tag_i,
  input  wire  l1_coherence_pkg::tag_t         [NUM_WAYS-1:0] tags_i,
  input  wire  l1_coherence_pkg::line_status_t [NUM_WAYS-1:0] status_i,
  output logic                                                hit_o,
  output logic [$clog2(NUM_WAYS)-1:0]                         hit_way_o,
  output l1_coherence_pkg::line_status_t                      hit_status_o,
  output logic                                                all_valid_o,
  output logic [$clog2(NUM_WAYS)-1:0]                         free_way_o
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  always_comb begin
    hit_o        = 1'b0;
    hit_way_o    = '0;
    hit_status_o = '0;
    all_valid_o  = 1'b1;
    free_way_o   = '0;
    // walk from the top way down so the lowest match is the one that sticks
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!status_i[w][l1_coherence_pkg::ST_VALID]) begin
        all_valid_o = 1'b0;
        free_way_o  = WAY_W'(w);
      end
      if (status_i[w][l1_coherence_pkg::ST_VALID] && (tags_i[w] == tag_i)) begin
        hit_o        = 1'b1;
        hit_way_o    = WAY_W'(w);
        hit_status_o = status_i[w];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/victim_select.sv
/* Fill way selection for CPU misses.
   Takes the free way when there is one, else the low bits of the replacement LFSR. */
`default_nettype none

module victim_select #(
  parameter int NUM_WAYS = 4
) (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          all_valid_i,
  input  wire  [$clog2(NUM_WAYS)-1:0]  free_way_i,
  input  wire                          advance_i,
  output logic [$clog2(NUM_WAYS)-1:0]  fill_way_o
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  l1_coherence_pkg::lfsr_t lfsr_q;
  logic                    feedback;

  // xnor of taps 7, 3, 2, 1 so the all-zero reset value still moves
  assign feedback = ~(lfsr_q[7] ^ lfsr_q[3] ^ lfsr_q[2] ^ lfsr_q[1]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= '0;
    end else if (advance_i) begin
      lfsr_q <= {lfsr_q[6:0], feedback};
    end
  end

  assign fill_way_o = all_valid_i ? lfsr_q[WAY_W-1:0] : free_way_i;

endmodule

`default_nettype wire

//--- design/state_update.sv
/* Next line state and response flags for the request in the lookup stage.
   Drives the array write port and the LFSR advance; the top gates both with its valid. */
`default_nettype none

module state_update #(
  parameter int NUM_WAYS = 4
) (
  input  wire                                  is_snoop_i,
  input  wire                                  we_i,
  input  wire                                  bypass_i,
  input  wire  l1_coherence_pkg::snoop_op_t    snoop_op_i,
  input  wire  l1_coherence_pkg::tag_t         tag_i,
  input  wire                                  hit_i,
  input  wire  [$clog2(NUM_WAYS)-1:0]          hit_way_i,
  input  wire  l1_coherence_pkg::line_status_t hit_status_i,
  input  wire  [$clog2(NUM_WAYS)-1:0]          fill_way_i,
  input  wire  l1_coherence_pkg::line_status_t victim_status_i,
  output logic                                 wr_en_o,
  output logic [$clog2(NUM_WAYS)-1:0]          wr_way_o,
  output l1_coherence_pkg::tag_t               wr_tag_o,
  output l1_coherence_pkg::line_status_t       wr_status_o,
  output logic                                 advance_o,
  output logic                                 hit_o,
  output logic [$clog2(NUM_WAYS)-1:0]          way_o,
  output logic                                 upgrade_o,
  output logic                                 writeback_o,
  output logic                                 is_shared_o,
  output logic                                 pass_dirty_o,
  output logic                                 data_transfer_o,
  output logic                                 error_o
);

  logic hit_dirty;
  logic hit_shared;

  assign hit_dirty  = hit_i & hit_status_i[l1_coherence_pkg::ST_DIRTY];
  assign hit_shared = hit_i & hit_status_i[l1_coherence_pkg::ST_SHARED];

  always_comb begin
    wr_en_o         = 1'b0;
    wr_way_o        = hit_way_i;
    wr_tag_o        = tag_i;
    wr_status_o     = hit_status_i;
    advance_o       = 1'b0;
    hit_o           = 1'b0;
    way_o           = '0;
    upgrade_o       = 1'b0;
    writeback_o     = 1'b0;
    is_shared_o     = 1'b0;
    pass_dirty_o    = 1'b0;
    data_transfer_o = 1'b0;
    error_o         = 1'b0;

    if (is_snoop_i) begin
      // flags always reflect the line before this snoop touches it
      case (snoop_op_i)
        l1_coherence_pkg::SNOOP_READ_ONCE: begin
          is_shared_o     = hit_shared;
          pass_dirty_o    = hit_dirty;
          data_transfer_o = hit_i;
        end
        l1_coherence_pkg::SNOOP_READ_SHARED: begin
          is_shared_o     = hit_shared;
          pass_dirty_o    = hit_dirty;
          data_transfer_o = hit_i;
          wr_en_o         = hit_i;
          wr_status_o[l1_coherence_pkg::ST_SHARED] = 1'b1;
        end
        l1_coherence_pkg::SNOOP_READ_UNIQUE: begin
          is_shared_o     = hit_shared;
          pass_dirty_o    = hit_dirty;
          data_transfer_o = hit_i;
          wr_en_o         = hit_i;
          wr_status_o     = '0;
        end
        l1_coherence_pkg::SNOOP_CLEAN_INVALID: begin
          pass_dirty_o    = hit_dirty;
          data_transfer_o = hit_dirty;
          wr_en_o         = hit_i;
          wr_status_o     = '0;
        end
        default: begin
          error_o = 1'b1;
        end
      endcase
    end else if (!bypass_i) begin
      hit_o = hit_i;
      if (hit_i) begin
        way_o     = hit_way_i;
        upgrade_o = we_i & hit_shared;
        if (we_i) begin
          wr_en_o = 1'b1;
          wr_status_o[l1_coherence_pkg::ST_DIRTY]  = 1'b1;
          wr_status_o[l1_coherence_pkg::ST_SHARED] = 1'b0;
        end
      end else begin
        way_o       = fill_way_i;
        wr_en_o     = 1'b1;
        wr_way_o    = fill_way_i;
        wr_status_o = '0;
        wr_status_o[l1_coherence_pkg::ST_VALID] = 1'b1;
        wr_status_o[l1_coherence_pkg::ST_DIRTY] = we_i;
        writeback_o = victim_status_i[l1_coherence_pkg::ST_VALID] &
                      victim_status_i[l1_coherence_pkg::ST_DIRTY];
        // the victim is only valid when the set had no free way left
        advance_o   = victim_status_i[l1_coherence_pkg::ST_VALID];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/coherence_dir_top.sv
/* Coherence directory for the L1 data cache tag and status arrays.
   Takes one CPU and one snoop strobe per cycle and answers two edges later. */
`default_nettype none

module coherence_dir_top #(
  parameter int                      NUM_WAYS        = 4,
  parameter l1_coherence_pkg::addr_t CACHE_BASE_ADDR = 32'h8000_0000
) (
  input  wire                               clk_i,
  input  wire                               rst_i,
  input  wire                               cpu_req_i,
  input  wire                               cpu_we_i,
  input  wire  l1_coherence_pkg::addr_t     cpu_addr_i,
  input  wire                               snoop_valid_i,
  input  wire  l1_coherence_pkg::snoop_op_t snoop_op_i,
  input  wire  l1_coherence_pkg::addr_t     snoop_addr_i,
  output logic                              resp_valid_o,
  output logic                              resp_hit_o,
  output logic [$clog2(NUM_WAYS)-1:0]       resp_way_o,
  output logic                              resp_bypass_o,
  output logic                              resp_upgrade_o,
  output logic                              resp_writeback_o,
  output logic                              cr_valid_o,
  output logic                              cr_is_shared_o,
  output logic                              cr_pass_dirty_o,
  output logic                              cr_data_transfer_o,
  output logic                              cr_error_o
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  l1_coherence_pkg::addr_t    req_addr;
  l1_coherence_pkg::set_idx_t req_set;
  logic                       cpu_accept;
  logic                       req_bypass;
  logic                       rd_en;

  // lookup stage
  logic                         s1_valid_q;
  logic                         s1_snoop_q;
  logic                         s1_we_q;
  logic                         s1_bypass_q;
  l1_coherence_pkg::snoop_op_t  s1_op_q;
  l1_coherence_pkg::set_idx_t   s1_set_q;
  l1_coherence_pkg::tag_t       s1_tag_q;

  l1_coherence_pkg::tag_t         [NUM_WAYS-1:0] rd_tags;
  l1_coherence_pkg::line_status_t [NUM_WAYS-1:0] rd_status;

  logic                           hit;
  logic [WAY_W-1:0]               hit_way;
  l1_coherence_pkg::line_status_t hit_status;
  logic                           all_valid;
  logic [WAY_W-1:0]               free_way;
  logic [WAY_W-1:0]               fill_way;
  l1_coherence_pkg::line_status_t victim_status;

  logic                           upd_wr_en;
  logic [WAY_W-1:0]               upd_wr_way;
  l1_coherence_pkg::tag_t         upd_wr_tag;
  l1_coherence_pkg::line_status_t upd_wr_status;
  logic                           upd_advance;
  logic                           upd_hit;
  logic [WAY_W-1:0]               upd_way;
  logic                           upd_upgrade;
  logic                           upd_writeback;
  logic                           upd_is_shared;
  logic                           upd_pass_dirty;
  logic                           upd_data_transfer;
  logic                           upd_error;

  // snoop wins, a CPU strobe in the same cycle is lost
  assign cpu_accept = cpu_req_i & ~snoop_valid_i;
  assign req_addr   = snoop_valid_i ? snoop_addr_i : cpu_addr_i;
  assign req_set    = req_addr[l1_coherence_pkg::OFFSET_W +: l1_coherence_pkg::SET_IDX_W];
  assign req_bypass = cpu_accept & (cpu_addr_i < CACHE_BASE_ADDR);
  assign rd_en      = (snoop_valid_i | cpu_accept) & ~req_bypass;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= snoop_valid_i | cpu_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_snoop_q  <= snoop_valid_i;
    s1_we_q     <= cpu_we_i;
    s1_bypass_q <= req_bypass;
    s1_op_q     <= snoop_op_i;
    s1_set_q    <= req_set;
    s1_tag_q    <= req_addr[l1_coherence_pkg::ADDR_W-1 -: l1_coherence_pkg::TAG_W];
  end

  tag_status_array #(
    .NUM_WAYS (NUM_WAYS)
  ) u_array (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_en_i     (rd_en),
    .rd_set_i    (req_set),
    .wr_en_i     (upd_wr_en & s1_valid_q),
    .wr_set_i    (s1_set_q),
    .wr_way_i    (upd_wr_way),
    .wr_tag_i    (upd_wr_tag),
    .wr_status_i (upd_wr_status),
    .rd_tags_o   (rd_tags),
    .rd_status_o (rd_status)
  );

  way_lookup #(
    .NUM_WAYS (NUM_WAYS)
  ) u_lookup (
    .tag_i        (s1_tag_q),
    .tags_i       (rd_tags),
    .status_i     (rd_status),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .hit_status_o (hit_status),
    .all_valid_o  (all_valid),
    .free_way_o   (free_way)
  );

  victim_select #(
    .NUM_WAYS (NUM_WAYS)
  ) u_victim (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .all_valid_i (all_valid),
    .free_way_i  (free_way),
    .advance_i   (upd_advance & s1_valid_q),
    .fill_way_o  (fill_way)
  );

  assign victim_status = rd_status[fill_way];

  state_update #(
    .NUM_WAYS (NUM_WAYS)
  ) u_update (
    .is_snoop_i      (s1_snoop_q),
    .we_i            (s1_we_q),
    .bypass_i        (s1_bypass_q),
    .snoop_op_i      (s1_op_q),
    .tag_i           (s1_tag_q),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .hit_status_i    (hit_status),
    .fill_way_i      (fill_way),
    .victim_status_i (victim_status),
    .wr_en_o         (upd_wr_en),
    .wr_way_o        (upd_wr_way),
    .wr_tag_o        (upd_wr_tag),
    .wr_status_o     (upd_wr_status),
    .advance_o       (upd_advance),
    .hit_o           (upd_hit),
    .way_o           (upd_way),
    .upgrade_o       (upd_upgrade),
    .writeback_o     (upd_writeback),
    .is_shared_o     (upd_is_shared),
    .pass_dirty_o    (upd_pass_dirty),
    .data_transfer_o (upd_data_transfer),
    .error_o         (upd_error)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
      cr_valid_o   <= 1'b0;
    end else begin
      resp_valid_o <= s1_valid_q & ~s1_snoop_q;
      cr_valid_o   <= s1_valid_q & s1_snoop_q;
    end
  end

  // response payload, only meaningful alongside the valid pulses
  always_ff @(posedge clk_i) begin
    resp_hit_o         <= upd_hit;
    resp_way_o         <= upd_way;
    resp_bypass_o      <= s1_bypass_q;
    resp_upgrade_o     <= upd_upgrade;
    resp_writeback_o   <= upd_writeback;
    cr_is_shared_o     <= upd_is_shared;
    cr_pass_dirty_o    <= upd_pass_dirty;
    cr_data_transfer_o <= upd_data_transfer;
    cr_error_o         <= upd_error;
  end

endmodule

`default_nettype wire

//--- verif/coherence_dir_checker.sv
/* Reference model of the coherence directory that watches the DUT outputs.
   The testbench hands each request over with push_req; responses are compared two edges later. */
`default_nettype none

module coherence_dir_checker #(
  parameter int NUM_WAYS = 4,
  parameter l1_coherence_pkg::addr_t CACHE_BASE_ADDR = 32'h8000_0000
) (
  input wire                        clk_i,
  input wire                        rst_i,
  input wire                        resp_valid_i,
  input wire                        resp_hit_i,
  input wire [$clog2(NUM_WAYS)-1:0] resp_way_i,
  input wire                        resp_bypass_i,
  input wire                        resp_upgrade_i,
  input wire                        resp_writeback_i,
  input wire                        cr_valid_i,
  input wire                        cr_is_shared_i,
  input wire                        cr_pass_dirty_i,
  input wire                        cr_data_transfer_i,
  input wire                        cr_error_i
);

  localparam int NUM_SETS = 2 ** l1_coherence_pkg::SET_IDX_W;

  typedef struct {
    string                       name;
    bit                          snoop;
    bit                          we;
    l1_coherence_pkg::snoop_op_t op;
    l1_coherence_pkg::addr_t     addr;
    bit                          has_exp;
    bit                          exp_flag;
    int                          due;
  } req_t;

  l1_coherence_pkg::tag_t         m_tags   [NUM_SETS][NUM_WAYS];
  l1_coherence_pkg::line_status_t m_status [NUM_SETS][NUM_WAYS];
  l1_coherence_pkg::lfsr_t        m_lfsr;

  req_t pend_q[$];
  int   cycle = 0;
  int   value_errors = 0;
  int   protocol_errors = 0;
  int   checked = 0;

  initial begin
    m_lfsr = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tags[s][w]   = '0;
        m_status[s][w] = '0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // called by the testbench right after it drives a strobe
  task automatic push_req(input string name, input bit snoop, input bit we,
                          input l1_coherence_pkg::snoop_op_t op,
                          input l1_coherence_pkg::addr_t addr,
                          input bit has_exp, input bit exp_flag);
    req_t r;
    r.name     = name;
    r.snoop    = snoop;
    r.we       = we;
    r.op       = op;
    r.addr     = addr;
    r.has_exp  = has_exp;
    r.exp_flag = exp_flag;
    r.due      = cycle + 2;
    pend_q.push_back(r);
  endtask

  task automatic check_val(input string name, input string field, input int exp,
                           input int act);
    if (exp != act) begin
      $display("** Error %s %s: expected %0h actual %0h", name, field, exp, act);
      value_errors++;
    end
  endtask

  function automatic l1_coherence_pkg::lfsr_t lfsr_next(input l1_coherence_pkg::lfsr_t v);
    return {v[6:0], ~(v[7] ^ v[3] ^ v[2] ^ v[1])};
  endfunction

  task automatic check_one(input req_t r);
    int  set;
    int  way;
    bit  hit;
    bit  dirty;
    bit  shared;
    bit  victim_dirty;
    int  free_way;
    l1_coherence_pkg::tag_t tag;
    set      = int'(r.addr[7:4]);
    tag      = r.addr[31:8];
    hit      = 1'b0;
    way      = 0;
    free_way = -1;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!m_status[set][w][0]) begin
        free_way = w;
      end else if (m_tags[set][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    dirty  = hit && m_status[set][way][1];
    shared = hit && m_status[set][way][2];
    checked++;

    if (r.snoop) begin
      if (!cr_valid_i || resp_valid_i) begin
        $display("missing coherence response pulse for %s", r.name);
        protocol_errors++;
      end
      if (r.op == 4'd0 || r.op == 4'd1 || r.op == 4'd7) begin
        check_val(r.name, "is_shared", shared, cr_is_shared_i);
        check_val(r.name, "pass_dirty", dirty, cr_pass_dirty_i);
        check_val(r.name, "data_transfer", hit, cr_data_transfer_i);
        check_val(r.name, "error", 0, cr_error_i);
        if (hit && r.op == 4'd1) begin
          m_status[set][way][2] = 1'b1;
        end
        if (hit && r.op == 4'd7) begin
          m_status[set][way] = '0;
        end
      end else if (r.op == 4'd9) begin
        check_val(r.name, "is_shared", 0, cr_is_shared_i);
        check_val(r.name, "pass_dirty", dirty, cr_pass_dirty_i);
        check_val(r.name, "data_transfer", dirty, cr_data_transfer_i);
        check_val(r.name, "error", 0, cr_error_i);
        if (hit) begin
          m_status[set][way] = '0;
        end
      end else begin
        check_val(r.name, "error", 1, cr_error_i);
        check_val(r.name, "is_shared", 0, cr_is_shared_i);
        check_val(r.name, "pass_dirty", 0, cr_pass_dirty_i);
        check_val(r.name, "data_transfer", 0, cr_data_transfer_i);
      end
      if (r.has_exp) begin
        check_val(r.name, "table error", r.exp_flag, cr_error_i);
      end
      return;
    end

    if (!resp_valid_i || cr_valid_i) begin
      $display("missing CPU response pulse for %s", r.name);
      protocol_errors++;
    end
    if (r.addr < CACHE_BASE_ADDR) begin
      // bypass leaves the model untouched
      check_val(r.name, "bypass", 1, resp_bypass_i);
      check_val(r.name, "hit", 0, resp_hit_i);
      check_val(r.name, "upgrade", 0, resp_upgrade_i);
      check_val(r.name, "writeback", 0, resp_writeback_i);
    end else if (hit) begin
      check_val(r.name, "bypass", 0, resp_bypass_i);
      check_val(r.name, "hit", 1, resp_hit_i);
      check_val(r.name, "way", way, resp_way_i);
      check_val(r.name, "upgrade", r.we && shared, resp_upgrade_i);
      check_val(r.name, "writeback", 0, resp_writeback_i);
      if (r.we) begin
        m_status[set][way][1] = 1'b1;
        m_status[set][way][2] = 1'b0;
      end
    end else begin
      if (free_way >= 0) begin
        way          = free_way;
        victim_dirty = 1'b0;
      end else begin
        way          = int'(m_lfsr) % NUM_WAYS;
        victim_dirty = m_status[set][way][1];
        m_lfsr       = lfsr_next(m_lfsr);
      end
      check_val(r.name, "bypass", 0, resp_bypass_i);
      check_val(r.name, "hit", 0, resp_hit_i);
      check_val(r.name, "way", way, resp_way_i);
      check_val(r.name, "upgrade", 0, resp_upgrade_i);
      check_val(r.name, "writeback", victim_dirty, resp_writeback_i);
      m_tags[set][way]   = tag;
      m_status[set][way] = {1'b0, r.we, 1'b1};
    end
    if (r.has_exp) begin
      check_val(r.name, "table hit", r.exp_flag, resp_hit_i);
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (pend_q.size() > 0 && pend_q[0].due == cycle) begin
        check_one(pend_q.pop_front());
      end else if (resp_valid_i || cr_valid_i) begin
        $display("unexpected response pulse with no request in flight");
        protocol_errors++;
      end
    end
  end

  task automatic report();
    if (pend_q.size() != 0) begin
      $display("%0d requests never received a response", pend_q.size());
      protocol_errors++;
    end
    $display("checked %0d requests: %0d value errors, %0d protocol errors",
             checked, value_errors, protocol_errors);
  endtask

endmodule

`default_nettype wire

//--- verif/coherence_dir_tb.sv
/* Top testbench for the coherence directory.
   Applies a directed table and a random phase, then prints the closing verdict. */
`default_nettype none

module coherence_dir_tb;

  localparam int NUM_WAYS   = 4;
  localparam int RAND_COUNT = 200;
  localparam l1_coherence_pkg::addr_t BASE = 32'h8000_0000;

  typedef struct {
    string                       name;
    bit                          snoop;
    bit                          we;
    l1_coherence_pkg::snoop_op_t op;
    l1_coherence_pkg::addr_t     addr;
    bit                          exp_flag;
  } entry_t;

  entry_t table_q[$];

  logic                        clk_i = 1'b0;
  logic                        rst_i;
  logic                        cpu_req_i;
  logic                        cpu_we_i;
  l1_coherence_pkg::addr_t     cpu_addr_i;
  logic                        snoop_valid_i;
  l1_coherence_pkg::snoop_op_t snoop_op_i;
  l1_coherence_pkg::addr_t     snoop_addr_i;

  logic                        resp_valid_o;
  logic                        resp_hit_o;
  logic [$clog2(NUM_WAYS)-1:0] resp_way_o;
  logic                        resp_bypass_o;
  logic                        resp_upgrade_o;
  logic                        resp_writeback_o;
  logic                        cr_valid_o;
  logic                        cr_is_shared_o;
  logic                        cr_pass_dirty_o;
  logic                        cr_data_transfer_o;
  logic                        cr_error_o;

  always #2 clk_i = ~clk_i;

  coherence_dir_top #(
    .NUM_WAYS        (NUM_WAYS),
    .CACHE_BASE_ADDR (BASE)
  ) u_dut (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .cpu_req_i          (cpu_req_i),
    .cpu_we_i           (cpu_we_i),
    .cpu_addr_i         (cpu_addr_i),
    .snoop_valid_i      (snoop_valid_i),
    .snoop_op_i         (snoop_op_i),
    .snoop_addr_i       (snoop_addr_i),
    .resp_valid_o       (resp_valid_o),
    .resp_hit_o         (resp_hit_o),
    .resp_way_o         (resp_way_o),
    .resp_bypass_o      (resp_bypass_o),
    .resp_upgrade_o     (resp_upgrade_o),
    .resp_writeback_o   (resp_writeback_o),
    .cr_valid_o         (cr_valid_o),
    .cr_is_shared_o     (cr_is_shared_o),
    .cr_pass_dirty_o    (cr_pass_dirty_o),
    .cr_data_transfer_o (cr_data_transfer_o),
    .cr_error_o         (cr_error_o)
  );

  coherence_dir_checker #(
    .NUM_WAYS        (NUM_WAYS),
    .CACHE_BASE_ADDR (BASE)
  ) u_chk (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .resp_valid_i       (resp_valid_o),
    .resp_hit_i         (resp_hit_o),
    .resp_way_i         (resp_way_o),
    .resp_bypass_i      (resp_bypass_o),
    .resp_upgrade_i     (resp_upgrade_o),
    .resp_writeback_i   (resp_writeback_o),
    .cr_valid_i         (cr_valid_o),
    .cr_is_shared_i     (cr_is_shared_o),
    .cr_pass_dirty_i    (cr_pass_dirty_o),
    .cr_data_transfer_i (cr_data_transfer_o),
    .cr_error_i         (cr_error_o)
  );

  task automatic add_entry(input string name, input bit snoop, input bit we,
                           input l1_coherence_pkg::snoop_op_t op,
                           input l1_coherence_pkg::addr_t addr, input bit exp_flag);
    entry_t e;
    e.name     = name;
    e.snoop    = snoop;
    e.we       = we;
    e.op       = op;
    e.addr     = addr;
    e.exp_flag = exp_flag;
    table_q.push_back(e);
  endtask

  task automatic drive_idle();
    cpu_req_i     = 1'b0;
    cpu_we_i      = 1'b0;
    cpu_addr_i    = '0;
    snoop_valid_i = 1'b0;
    snoop_op_i    = '0;
    snoop_addr_i  = '0;
  endtask

  task automatic issue(input string name, input bit snoop, input bit we,
                       input l1_coherence_pkg::snoop_op_t op,
                       input l1_coherence_pkg::addr_t addr,
                       input bit has_exp, input bit exp_flag);
    drive_idle();
    if (snoop) begin
      snoop_valid_i = 1'b1;
      snoop_op_i    = op;
      snoop_addr_i  = addr;
    end else begin
      cpu_req_i  = 1'b1;
      cpu_we_i   = we;
      cpu_addr_i = addr;
    end
    u_chk.push_req(name, snoop, we, op, addr, has_exp, exp_flag);
  endtask

  task automatic build_table();
    add_entry("read_miss", 0, 0, 4'd0, 32'h8000_0010, 0);
    add_entry("read_hit", 0, 0, 4'd0, 32'h8000_0010, 1);
    add_entry("write_hit", 0, 1, 4'd0, 32'h8000_0010, 1);
    add_entry("snoop_once_dirty", 1, 0, 4'd0, 32'h8000_0010, 0);
    add_entry("snoop_shared", 1, 0, 4'd1, 32'h8000_0010, 0);
    add_entry("write_upgrade", 0, 1, 4'd0, 32'h8000_0010, 1);
    add_entry("snoop_unique", 1, 0, 4'd7, 32'h8000_0010, 0);
    add_entry("read_after_unique", 0, 0, 4'd0, 32'h8000_0010, 0);
    add_entry("write_dirty", 0, 1, 4'd0, 32'h8000_0010, 1);
    add_entry("clean_invalid", 1, 0, 4'd9, 32'h8000_0010, 0);
    add_entry("read_after_clean", 0, 0, 4'd0, 32'h8000_0010, 0);
    add_entry("snoop_unknown", 1, 0, 4'd3, 32'h8000_0010, 1);
    add_entry("bypass_read", 0, 1, 4'd0, 32'h0000_1010, 0);
    add_entry("read_after_bypass", 0, 0, 4'd0, 32'h8000_0010, 1);
    // six writes into set 2 fill all ways, then evict dirty victims
    for (int k = 0; k < 6; k++) begin
      add_entry($sformatf("evict_fill_%0d", k), 0, 1, 4'd0, 32'h8000_0020 + k * 32'h100, 0);
    end
    add_entry("evicted_read", 0, 0, 4'd0, 32'h8000_0020, 0);
    add_entry("kept_read", 0, 0, 4'd0, 32'h8000_0220, 1);
    add_entry("b2b_write_miss", 0, 1, 4'd0, 32'h8000_0030, 0);
    add_entry("b2b_read_hit", 0, 0, 4'd0, 32'h8000_0030, 1);
  endtask

  // watchdog
  initial begin
    #1;
    #((table_q.size() + RAND_COUNT + 20) * 4 * 4);
    $display("timeout: the run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    l1_coherence_pkg::snoop_op_t ops [5];
    l1_coherence_pkg::addr_t     addr;
    int                          kind;
    ops = '{4'd0, 4'd1, 4'd7, 4'd9, 4'd3};
    void'($urandom(32'h72ed_0394));
    rst_i = 1'b1;
    drive_idle();
    build_table();
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    foreach (table_q[i]) begin
      @(posedge clk_i);
      #1;
      issue(table_q[i].name, table_q[i].snoop, table_q[i].we, table_q[i].op,
            table_q[i].addr, 1'b1, table_q[i].exp_flag);
    end

    // random traffic on sets 5 and 6 with six tags, so evictions happen
    for (int i = 0; i < RAND_COUNT; i++) begin
      @(posedge clk_i);
      #1;
      kind = $urandom_range(0, 3);
      addr = BASE | ($urandom_range(0, 5) << 8) | ((5 + $urandom_range(0, 1)) << 4);
      if (kind == 0) begin
        drive_idle();
      end else if (kind == 1) begin
        issue("random_snoop", 1, 0, ops[$urandom_range(0, 4)], addr, 0, 0);
      end else begin
        if ($urandom_range(0, 9) == 0) begin
          addr[31] = 1'b0;
        end
        issue("random_cpu", 0, $urandom_range(0, 1), 4'd0, addr, 0, 0);
      end
    end

    @(posedge clk_i);
    #1;
    drive_idle();
    repeat (6) @(posedge clk_i);
    u_chk.report();
    if (u_chk.value_errors + u_chk.protocol_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- coherence_dir.f
design/l1_coherence_pkg.sv
design/tag_status_array.sv
design/way_lookup.sv
design/victim_select.sv
design/state_update.sv
design/coherence_dir_top.sv
verif/coherence_dir_checker.sv
verif/coherence_dir_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the coherence directory testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module coherence_dir_tb -f coherence_dir.f -o coherence_dir_sim

./obj_dir/coherence_dir_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
